//--- list.f
+incdir+verif
source/dispatch_pkg.sv
source/inst_decode.sv
source/dispatch.sv
source/resource_tracker.sv
source/dispatch_stage_top.sv
verif/tb_dispatch_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dispatch_stage \
    -f list.f -o sim_dispatch_stage \
    && ./obj_dir/sim_dispatch_stage | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- source/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic                      [dispatch_pkg::N-1:0] dec_valid,
    input  dispatch_pkg::inst_class_t [dispatch_pkg::N-1:0] dec_class,
    input  dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rd,
    input  dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rs1,
    input  dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rs2,
    input  dispatch_pkg::lane_cnt_t                         rob_open,
    input  dispatch_pkg::lane_cnt_t                         rs_open,
    input  dispatch_pkg::lane_cnt_t                         sq_open,
    input  dispatch_pkg::sq_idx_t                           sq_tail,
    input  logic                                            bs_full,
    output logic                      [dispatch_pkg::N-1:0] out_valid,
    output dispatch_pkg::inst_class_t [dispatch_pkg::N-1:0] out_class,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rd,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rs1,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rs2,
    output dispatch_pkg::sq_idx_t     [dispatch_pkg::N-1:0] out_sq_idx,
    output dispatch_pkg::lane_cnt_t                         num_dispatch,
    output dispatch_pkg::lane_cnt_t                         num_store_dispatched,
    output logic                                            br_dispatched
);

    dispatch_pkg::lane_cnt_t num_valid;
    dispatch_pkg::lane_cnt_t rob_rs_open;
    dispatch_pkg::lane_cnt_t limit;
    dispatch_pkg::lane_cnt_t n_taken;
    dispatch_pkg::lane_cnt_t n_store;
    logic                    stop;
    logic                    br_taken;

    always_comb begin
        num_valid = '0;
        for (int i = 0; i < dispatch_pkg::N; i++) begin
            if (dec_valid[i]) begin
                num_valid = num_valid + 3'd1;
            end
        end
    end

    assign rob_rs_open = (rob_open < rs_open) ? rob_open : rs_open;
    assign limit       = (num_valid < rob_rs_open) ? num_valid : rob_rs_open;

    // in-order scan, first blocked lane ends the bundle
    always_comb begin
        out_valid = '0;
        out_rd    = '0;
        out_rs1   = '0;
        out_rs2   = '0;
        out_sq_idx = '0;
        for (int i = 0; i < dispatch_pkg::N; i++) begin
            out_class[i] = dispatch_pkg::CLASS_ALU;
        end
        n_taken  = '0;
        n_store  = '0;
        stop     = 1'b0;
        br_taken = 1'b0;

        for (int i = 0; i < dispatch_pkg::N; i++) begin
            if (!stop && dec_valid[i] && (dispatch_pkg::lane_cnt_t'(i) < limit)) begin
                case (dec_class[i])
                    dispatch_pkg::CLASS_BRANCH,
                    dispatch_pkg::CLASS_JUMP: begin
                        // control flow only from lane 0
                        if (i != 0 || bs_full) begin
                            stop = 1'b1;
                        end else begin
                            br_taken = 1'b1;
                        end
                    end
                    dispatch_pkg::CLASS_STORE: begin
                        if (n_store >= sq_open) begin
                            stop = 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase

                if (!stop) begin
                    out_valid[i] = 1'b1;
                    out_class[i] = dec_class[i];
                    out_rd[i]    = dec_rd[i];
                    out_rs1[i]   = dec_rs1[i];
                    out_rs2[i]   = dec_rs2[i];
                    if (dec_class[i] == dispatch_pkg::CLASS_STORE ||
                        dec_class[i] == dispatch_pkg::CLASS_LOAD) begin
                        out_sq_idx[i] = dispatch_pkg::sq_idx_t'(
                            (32'(sq_tail) + 32'(n_store)) % dispatch_pkg::SQ_SZ);
                    end
                    // loads share the index, only stores advance it
                    if (dec_class[i] == dispatch_pkg::CLASS_STORE) begin
                        n_store = n_store + 3'd1;
                    end
                    n_taken = n_taken + 3'd1;
                end
            end
        end
    end

    assign num_dispatch         = n_taken;
    assign num_store_dispatched = n_store;
    assign br_dispatched        = br_taken;

endmodule

//--- source/dispatch_pkg.sv
package dispatch_pkg;

    // dispatch width in lanes
    localparam int N = 4;

    // back-end structure sizes
    localparam int ROB_SZ = 16;
    localparam int RS_SZ  = 8;
    localparam int SQ_SZ  = 8;
    localparam int BS_SZ  = 4;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // count of lanes, 0 to N
    typedef logic [2:0] lane_cnt_t;

    // store queue entry index
    typedef logic [2:0] sq_idx_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // occupancy of a tracked structure, 0 to 16
    typedef logic [4:0] occ_cnt_t;

    typedef enum logic [2:0] {
        CLASS_ALU    = 3'd0,
        CLASS_LOAD   = 3'd1,
        CLASS_STORE  = 3'd2,
        CLASS_BRANCH = 3'd3,
        CLASS_JUMP   = 3'd4
    } inst_class_t;

    // rv32 major opcodes, bits [6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

endpackage

//--- source/dispatch_stage_top.sv
`timescale 1ns/1ps

module dispatch_stage_top (
    input  logic                                            clock,
    input  logic                                            rst,
    input  logic                      [dispatch_pkg::N-1:0] inst_valid,
    input  dispatch_pkg::inst_t       [dispatch_pkg::N-1:0] insts,
    input  dispatch_pkg::lane_cnt_t                         rob_retire,
    input  dispatch_pkg::lane_cnt_t                         rs_issue,
    input  dispatch_pkg::lane_cnt_t                         sq_commit,
    input  logic                                            br_resolve,
    output logic                      [dispatch_pkg::N-1:0] out_valid,
    output dispatch_pkg::inst_class_t [dispatch_pkg::N-1:0] out_class,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rd,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rs1,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rs2,
    output dispatch_pkg::sq_idx_t     [dispatch_pkg::N-1:0] out_sq_idx,
    output dispatch_pkg::lane_cnt_t                         num_dispatch,
    output dispatch_pkg::lane_cnt_t                         num_store_dispatched
);

    // decode to dispatch
    logic                      [dispatch_pkg::N-1:0] dec_valid;
    dispatch_pkg::inst_class_t [dispatch_pkg::N-1:0] dec_class;
    dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rd;
    dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rs1;
    dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rs2;

    // tracker to dispatch
    dispatch_pkg::lane_cnt_t rob_open;
    dispatch_pkg::lane_cnt_t rs_open;
    dispatch_pkg::lane_cnt_t sq_open;
    dispatch_pkg::sq_idx_t   sq_tail;
    logic                    bs_full;

    // dispatch back to tracker
    logic                    br_dispatched;

    inst_decode i_decode (
        .insts      (insts),
        .inst_valid (inst_valid),
        .dec_valid  (dec_valid),
        .dec_class  (dec_class),
        .dec_rd     (dec_rd),
        .dec_rs1    (dec_rs1),
        .dec_rs2    (dec_rs2)
    );

    dispatch i_dispatch (
        .dec_valid            (dec_valid),
        .dec_class            (dec_class),
        .dec_rd               (dec_rd),
        .dec_rs1              (dec_rs1),
        .dec_rs2              (dec_rs2),
        .rob_open             (rob_open),
        .rs_open              (rs_open),
        .sq_open              (sq_open),
        .sq_tail              (sq_tail),
        .bs_full              (bs_full),
        .out_valid            (out_valid),
        .out_class            (out_class),
        .out_rd               (out_rd),
        .out_rs1              (out_rs1),
        .out_rs2              (out_rs2),
        .out_sq_idx           (out_sq_idx),
        .num_dispatch         (num_dispatch),
        .num_store_dispatched (num_store_dispatched),
        .br_dispatched        (br_dispatched)
    );

    resource_tracker i_tracker (
        .clock                (clock),
        .rst                  (rst),
        .num_dispatch         (num_dispatch),
        .num_store_dispatched (num_store_dispatched),
        .rob_retire           (rob_retire),
        .rs_issue             (rs_issue),
        .sq_commit            (sq_commit),
        .br_dispatched        (br_dispatched),
        .br_resolve           (br_resolve),
        .rob_open             (rob_open),
        .rs_open              (rs_open),
        .sq_open              (sq_open),
        .bs_full              (bs_full),
        .sq_tail              (sq_tail)
    );

endmodule

//--- source/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  dispatch_pkg::inst_t       [dispatch_pkg::N-1:0] insts,
    input  logic                      [dispatch_pkg::N-1:0] inst_valid,
    output logic                      [dispatch_pkg::N-1:0] dec_valid,
    output dispatch_pkg::inst_class_t [dispatch_pkg::N-1:0] dec_class,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rd,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rs1,
    output dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] dec_rs2
);

    // major opcode to instruction class
    function automatic dispatch_pkg::inst_class_t classify(input dispatch_pkg::inst_t inst);
        case (inst[6:0])
            dispatch_pkg::OPC_BRANCH: return dispatch_pkg::CLASS_BRANCH;
            dispatch_pkg::OPC_JAL,
            dispatch_pkg::OPC_JALR:   return dispatch_pkg::CLASS_JUMP;
            dispatch_pkg::OPC_STORE:  return dispatch_pkg::CLASS_STORE;
            dispatch_pkg::OPC_LOAD:   return dispatch_pkg::CLASS_LOAD;
            default:                  return dispatch_pkg::CLASS_ALU;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < dispatch_pkg::N; i++) begin
            // an all-zero word is never a real instruction
            dec_valid[i] = inst_valid[i] && (insts[i] != '0);
            dec_class[i] = dispatch_pkg::CLASS_ALU;
            dec_rd[i]    = '0;
            dec_rs1[i]   = '0;
            dec_rs2[i]   = '0;

            if (dec_valid[i]) begin
                dec_class[i] = classify(insts[i]);

                case (insts[i][6:0])
                    dispatch_pkg::OPC_LOAD: begin
                        dec_rd[i]  = insts[i][11:7];
                        dec_rs1[i] = insts[i][19:15];
                    end
                    // no destination for stores and branches
                    dispatch_pkg::OPC_STORE,
                    dispatch_pkg::OPC_BRANCH: begin
                        dec_rs1[i] = insts[i][19:15];
                        dec_rs2[i] = insts[i][24:20];
                    end
                    dispatch_pkg::OPC_JAL,
                    dispatch_pkg::OPC_LUI,
                    dispatch_pkg::OPC_AUIPC: begin
                        dec_rd[i] = insts[i][11:7];
                    end
                    dispatch_pkg::OPC_JALR: begin
                        dec_rd[i]  = insts[i][11:7];
                        dec_rs1[i] = insts[i][19:15];
                    end
                    dispatch_pkg::OPC_OP: begin
                        dec_rd[i]  = insts[i][11:7];
                        dec_rs1[i] = insts[i][19:15];
                        dec_rs2[i] = insts[i][24:20];
                    end
                    default: begin
                        // immediate forms, one source
                        dec_rd[i]  = insts[i][11:7];
                        dec_rs1[i] = insts[i][19:15];
                    end
                endcase
            end
        end
    end

endmodule

//--- source/resource_tracker.sv
`timescale 1ns/1ps

module resource_tracker (
    input  logic                    clock,
    input  logic                    rst,
    input  dispatch_pkg::lane_cnt_t num_dispatch,
    input  dispatch_pkg::lane_cnt_t num_store_dispatched,
    input  dispatch_pkg::lane_cnt_t rob_retire,
    input  dispatch_pkg::lane_cnt_t rs_issue,
    input  dispatch_pkg::lane_cnt_t sq_commit,
    input  logic                    br_dispatched,
    input  logic                    br_resolve,
    output dispatch_pkg::lane_cnt_t rob_open,
    output dispatch_pkg::lane_cnt_t rs_open,
    output dispatch_pkg::lane_cnt_t sq_open,
    output logic                    bs_full,
    output dispatch_pkg::sq_idx_t   sq_tail
);

    dispatch_pkg::occ_cnt_t rob_occ;
    dispatch_pkg::occ_cnt_t rs_occ;
    dispatch_pkg::occ_cnt_t sq_occ;
    dispatch_pkg::occ_cnt_t bs_occ;

    dispatch_pkg::occ_cnt_t rob_free;
    dispatch_pkg::occ_cnt_t rs_free;
    dispatch_pkg::occ_cnt_t sq_free;
    dispatch_pkg::occ_cnt_t bs_free;

    // never release more than is held
    function automatic dispatch_pkg::occ_cnt_t clip_release(
        input dispatch_pkg::occ_cnt_t  occ,
        input dispatch_pkg::lane_cnt_t rel
    );
        dispatch_pkg::occ_cnt_t rel_w;
        rel_w = dispatch_pkg::occ_cnt_t'(rel);
        return (rel_w > occ) ? occ : rel_w;
    endfunction

    // free entries, saturated at the dispatch width
    function automatic dispatch_pkg::lane_cnt_t open_slots(
        input int                     size,
        input dispatch_pkg::occ_cnt_t occ
    );
        int free;
        free = size - int'(occ);
        if (free > dispatch_pkg::N) begin
            return dispatch_pkg::lane_cnt_t'(dispatch_pkg::N);
        end
        return dispatch_pkg::lane_cnt_t'(free);
    endfunction

    assign rob_free = clip_release(rob_occ, rob_retire);
    assign rs_free  = clip_release(rs_occ, rs_issue);
    assign sq_free  = clip_release(sq_occ, sq_commit);
    // single resolve per cycle
    assign bs_free  = (br_resolve && bs_occ != '0) ? 5'd1 : 5'd0;

    always_ff @(posedge clock) begin
        if (rst) begin
            rob_occ <= '0;
            rs_occ  <= '0;
            sq_occ  <= '0;
            bs_occ  <= '0;
            sq_tail <= '0;
        end else begin
            rob_occ <= rob_occ + dispatch_pkg::occ_cnt_t'(num_dispatch) - rob_free;
            rs_occ  <= rs_occ + dispatch_pkg::occ_cnt_t'(num_dispatch) - rs_free;
            sq_occ  <= sq_occ + dispatch_pkg::occ_cnt_t'(num_store_dispatched) - sq_free;
            bs_occ  <= bs_occ + dispatch_pkg::occ_cnt_t'(br_dispatched) - bs_free;
            sq_tail <= dispatch_pkg::sq_idx_t'(
                (32'(sq_tail) + 32'(num_store_dispatched)) % dispatch_pkg::SQ_SZ);
        end
    end

    assign rob_open = open_slots(dispatch_pkg::ROB_SZ, rob_occ);
    assign rs_open  = open_slots(dispatch_pkg::RS_SZ, rs_occ);
    assign sq_open  = open_slots(dispatch_pkg::SQ_SZ, sq_occ);
    assign bs_full  = (bs_occ == dispatch_pkg::occ_cnt_t'(dispatch_pkg::BS_SZ));

endmodule

//--- verif/tb_dispatch_model.svh
`ifndef TB_DISPATCH_MODEL_SVH
`define TB_DISPATCH_MODEL_SVH

// mirror of the tracker state
int m_rob_occ;
int m_rs_occ;
int m_sq_occ;
int m_bs_occ;
int m_sq_tail;

// expected outputs for the bundle on the inputs
logic                      [dispatch_pkg::N-1:0] exp_valid;
dispatch_pkg::inst_class_t [dispatch_pkg::N-1:0] exp_class;
dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] exp_rd;
dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] exp_rs1;
dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] exp_rs2;
dispatch_pkg::sq_idx_t     [dispatch_pkg::N-1:0] exp_sq_idx;
int                                              exp_num;
int                                              exp_stores;
logic                                            exp_br;

function automatic int open_count(input int size, input int occ);
    return (size - occ > dispatch_pkg::N) ? dispatch_pkg::N : size - occ;
endfunction

function automatic int clipped(input int rel, input int occ);
    return (rel > occ) ? occ : rel;
endfunction

function automatic void predict(input logic [dispatch_pkg::N-1:0] valid, input bundle_t words);
    logic [dispatch_pkg::N-1:0] live;
    int                         nvalid;
    int                         rob_room;
    int                         rs_room;
    int                         limit;
    int                         sq_room;
    int                         stores;
    logic                       stop;
    logic                       is_ctrl;
    dispatch_pkg::inst_class_t  cls;
    dispatch_pkg::reg_idx_t     rd;
    dispatch_pkg::reg_idx_t     rs1;
    dispatch_pkg::reg_idx_t     rs2;
    nvalid = 0;
    for (int i = 0; i < dispatch_pkg::N; i++) begin
        live[i] = valid[i] && (words[i] != 32'd0);
        if (live[i]) nvalid++;
        exp_class[i] = dispatch_pkg::CLASS_ALU;
    end
    rob_room = open_count(dispatch_pkg::ROB_SZ, m_rob_occ);
    rs_room  = open_count(dispatch_pkg::RS_SZ, m_rs_occ);
    limit    = nvalid;
    if (rob_room < limit) limit = rob_room;
    if (rs_room < limit) limit = rs_room;
    sq_room = open_count(dispatch_pkg::SQ_SZ, m_sq_occ);
    exp_valid  = '0;
    exp_rd     = '0;
    exp_rs1    = '0;
    exp_rs2    = '0;
    exp_sq_idx = '0;
    exp_num    = 0;
    exp_br     = 1'b0;
    stores     = 0;
    stop       = 1'b0;
    for (int i = 0; i < dispatch_pkg::N; i++) begin
        if (!stop && live[i] && i < limit) begin
            rd  = words[i][11:7];
            rs1 = words[i][19:15];
            rs2 = words[i][24:20];
            cls = dispatch_pkg::CLASS_ALU;
            // register fields used by each rv32 format
            case (words[i][6:0])
                dispatch_pkg::OPC_BRANCH: begin
                    cls = dispatch_pkg::CLASS_BRANCH;
                    rd  = '0;
                end
                dispatch_pkg::OPC_STORE: begin
                    cls = dispatch_pkg::CLASS_STORE;
                    rd  = '0;
                end
                dispatch_pkg::OPC_LOAD: begin
                    cls = dispatch_pkg::CLASS_LOAD;
                    rs2 = '0;
                end
                dispatch_pkg::OPC_JALR: begin
                    cls = dispatch_pkg::CLASS_JUMP;
                    rs2 = '0;
                end
                dispatch_pkg::OPC_JAL: begin
                    cls = dispatch_pkg::CLASS_JUMP;
                    rs1 = '0;
                    rs2 = '0;
                end
                dispatch_pkg::OPC_LUI,
                dispatch_pkg::OPC_AUIPC: begin
                    rs1 = '0;
                    rs2 = '0;
                end
                dispatch_pkg::OPC_OP: begin
                end
                default: rs2 = '0;
            endcase
            is_ctrl = (cls == dispatch_pkg::CLASS_BRANCH) ||
                      (cls == dispatch_pkg::CLASS_JUMP);
            if (is_ctrl && (i != 0 || m_bs_occ == dispatch_pkg::BS_SZ)) stop = 1'b1;
            if (cls == dispatch_pkg::CLASS_STORE && stores >= sq_room) stop = 1'b1;
            if (!stop) begin
                exp_valid[i] = 1'b1;
                exp_class[i] = cls;
                exp_rd[i]    = rd;
                exp_rs1[i]   = rs1;
                exp_rs2[i]   = rs2;
                if (cls == dispatch_pkg::CLASS_STORE || cls == dispatch_pkg::CLASS_LOAD) begin
                    exp_sq_idx[i] = dispatch_pkg::sq_idx_t'(
                        (m_sq_tail + stores) % dispatch_pkg::SQ_SZ);
                end
                if (cls == dispatch_pkg::CLASS_STORE) stores++;
                if (is_ctrl) exp_br = 1'b1;
                exp_num++;
            end
        end
    end
    exp_stores = stores;
endfunction

// state after the next rising edge
task automatic advance_model(input int rob_rel, input int rs_rel, input int sq_rel,
                             input logic resolve);
    int bs_rel;
    bs_rel    = (resolve && m_bs_occ > 0) ? 1 : 0;
    m_rob_occ = m_rob_occ + exp_num - clipped(rob_rel, m_rob_occ);
    m_rs_occ  = m_rs_occ + exp_num - clipped(rs_rel, m_rs_occ);
    m_sq_occ  = m_sq_occ + exp_stores - clipped(sq_rel, m_sq_occ);
    m_bs_occ  = m_bs_occ + (exp_br ? 1 : 0) - bs_rel;
    m_sq_tail = (m_sq_tail + exp_stores) % dispatch_pkg::SQ_SZ;
endtask

task automatic reset_model();
    m_rob_occ = 0;
    m_rs_occ  = 0;
    m_sq_occ  = 0;
    m_bs_occ  = 0;
    m_sq_tail = 0;
endtask

`endif

//--- verif/tb_dispatch_stage.sv
`timescale 1ns/1ps

module tb_dispatch_stage;

    typedef dispatch_pkg::inst_t [dispatch_pkg::N-1:0] bundle_t;

    // directed cycles are an upper estimate
    localparam int DIRECTED_CYCLES = 100;
    localparam int RAND_CYCLES     = 800;
    localparam int TIMEOUT_CYCLES  = 2 * (DIRECTED_CYCLES + RAND_CYCLES) + 200;

    logic                                            clock;
    logic                                            rst;
    logic                      [dispatch_pkg::N-1:0] inst_valid;
    bundle_t                                         insts;
    dispatch_pkg::lane_cnt_t                         rob_retire;
    dispatch_pkg::lane_cnt_t                         rs_issue;
    dispatch_pkg::lane_cnt_t                         sq_commit;
    logic                                            br_resolve;
    logic                      [dispatch_pkg::N-1:0] out_valid;
    dispatch_pkg::inst_class_t [dispatch_pkg::N-1:0] out_class;
    dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rd;
    dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rs1;
    dispatch_pkg::reg_idx_t    [dispatch_pkg::N-1:0] out_rs2;
    dispatch_pkg::sq_idx_t     [dispatch_pkg::N-1:0] out_sq_idx;
    dispatch_pkg::lane_cnt_t                         num_dispatch;
    dispatch_pkg::lane_cnt_t                         num_store_dispatched;

    int cycles;
    int checks;
    int errors;

    `include "tb_dispatch_model.svh"

    dispatch_stage_top i_dut (
        .clock(clock), .rst(rst), .inst_valid(inst_valid), .insts(insts),
        .rob_retire(rob_retire), .rs_issue(rs_issue), .sq_commit(sq_commit),
        .br_resolve(br_resolve), .out_valid(out_valid), .out_class(out_class),
        .out_rd(out_rd), .out_rs1(out_rs1), .out_rs2(out_rs2), .out_sq_idx(out_sq_idx),
        .num_dispatch(num_dispatch), .num_store_dispatched(num_store_dispatched)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles without finishing the tests", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic dispatch_pkg::inst_t alu_op(input int rd, input int rs1, input int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], dispatch_pkg::OPC_OP};
    endfunction

    function automatic dispatch_pkg::inst_t load_op(input int rd, input int rs1);
        return {12'h010, rs1[4:0], 3'b010, rd[4:0], dispatch_pkg::OPC_LOAD};
    endfunction

    function automatic dispatch_pkg::inst_t store_op(input int rs1, input int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b010, 5'h04, dispatch_pkg::OPC_STORE};
    endfunction

    function automatic dispatch_pkg::inst_t branch_op(input int rs1, input int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b001, 5'h08, dispatch_pkg::OPC_BRANCH};
    endfunction

    function automatic bundle_t bundle(input dispatch_pkg::inst_t w0, input dispatch_pkg::inst_t w1,
                                       input dispatch_pkg::inst_t w2, input dispatch_pkg::inst_t w3);
        return {w3, w2, w1, w0};
    endfunction

    function automatic dispatch_pkg::inst_t random_word();
        logic [31:0] bits;
        logic [6:0]  op;
        bits = $urandom;
        case ($urandom % 10)
            0: op = dispatch_pkg::OPC_OP;
            1: op = 7'b0010011;
            2: op = dispatch_pkg::OPC_LUI;
            3: op = dispatch_pkg::OPC_LOAD;
            4: op = dispatch_pkg::OPC_STORE;
            5: op = dispatch_pkg::OPC_BRANCH;
            6: op = dispatch_pkg::OPC_JAL;
            7: op = dispatch_pkg::OPC_JALR;
            8: op = dispatch_pkg::OPC_AUIPC;
            default: return bits;
        endcase
        if ($urandom % 20 == 0) return '0;
        return {bits[31:7], op};
    endfunction

    // apply one bundle and return 5 ns after the edge that takes it
    task automatic drive_cycle(input logic [dispatch_pkg::N-1:0] valid, input bundle_t words,
                               input int rob_rel, input int rs_rel, input int sq_rel,
                               input logic resolve);
        inst_valid = valid;
        insts      = words;
        rob_retire = dispatch_pkg::lane_cnt_t'(rob_rel);
        rs_issue   = dispatch_pkg::lane_cnt_t'(rs_rel);
        sq_commit  = dispatch_pkg::lane_cnt_t'(sq_rel);
        br_resolve = resolve;
        @(posedge clock);
        #5;
    endtask

    // drain every structure
    task automatic idle_cycles(input int count);
        repeat (count) drive_cycle('0, '0, 4, 4, 4, 1'b1);
    endtask

    task automatic random_cycles(input int count);
        bundle_t                    words;
        logic [dispatch_pkg::N-1:0] valid;
        for (int c = 0; c < count; c++) begin
            for (int i = 0; i < dispatch_pkg::N; i++) begin
                words[i] = random_word();
                valid[i] = ($urandom % 4) != 0;
            end
            drive_cycle(valid, words, $urandom % 5, $urandom % 5, $urandom % 4,
                        ($urandom % 3) == 0);
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < dispatch_pkg::N; i++) begin
            check_field($sformatf("out_valid[%0d]", i), 32'(out_valid[i]), 32'(exp_valid[i]));
            check_field($sformatf("out_class[%0d]", i), 32'(out_class[i]), 32'(exp_class[i]));
            check_field($sformatf("out_rd[%0d]", i), 32'(out_rd[i]), 32'(exp_rd[i]));
            check_field($sformatf("out_rs1[%0d]", i), 32'(out_rs1[i]), 32'(exp_rs1[i]));
            check_field($sformatf("out_rs2[%0d]", i), 32'(out_rs2[i]), 32'(exp_rs2[i]));
            check_field($sformatf("out_sq_idx[%0d]", i), 32'(out_sq_idx[i]), 32'(exp_sq_idx[i]));
        end
        check_field("num_dispatch", 32'(num_dispatch), 32'(exp_num));
        check_field("num_store_dispatched", 32'(num_store_dispatched), 32'(exp_stores));
    endtask

    // sample 10 ns before every rising edge
    initial begin
        forever begin
            @(negedge clock);
            #40;
            if (rst) begin
                reset_model();
            end else begin
                predict(inst_valid, insts);
                compare_outputs();
                advance_model(int'(rob_retire), int'(rs_issue), int'(sq_commit), br_resolve);
            end
        end
    end

    initial begin
        bundle_t alus;
        bundle_t stores;
        clock      = 1'b0;
        rst        = 1'b1;
        inst_valid = '0;
        insts      = '0;
        rob_retire = '0;
        rs_issue   = '0;
        sq_commit  = '0;
        br_resolve = 1'b0;
        cycles     = 0;
        checks     = 0;
        errors     = 0;
        void'($urandom(32'hb85a_c751));
        alus   = bundle(alu_op(1, 2, 3), alu_op(4, 5, 6), alu_op(7, 8, 9), alu_op(10, 11, 12));
        stores = bundle(store_op(1, 2), store_op(3, 4), store_op(5, 6), store_op(7, 8));
        repeat (2) @(posedge clock);
        #5;
        rst = 1'b0;

        // full bundle and a hole that lowers the limit
        drive_cycle(4'b1111, alus, 4, 4, 0, 1'b0);
        drive_cycle(4'b1011, alus, 4, 4, 0, 1'b0);
        idle_cycles(4);

        // rs fills first and then the rob with rs issuing
        repeat (3) drive_cycle(4'b1111, alus, 0, 0, 0, 1'b0);
        repeat (5) drive_cycle(4'b1111, alus, 0, 4, 0, 1'b0);
        // release and dispatch again on the next cycle
        repeat (2) drive_cycle(4'b1111, alus, 4, 4, 0, 1'b0);
        idle_cycles(6);

        // branch stack
        drive_cycle(4'b1111, bundle(branch_op(1, 2), alus[1], alus[2], alus[3]), 4, 4, 0, 1'b0);
        drive_cycle(4'b1111, bundle(alus[0], branch_op(3, 4), alus[2], alus[3]), 4, 4, 0, 1'b0);
        repeat (4) drive_cycle(4'b0001, bundle(branch_op(5, 6), '0, '0, '0), 4, 4, 0, 1'b0);
        drive_cycle(4'b0001, bundle(branch_op(5, 6), '0, '0, '0), 4, 4, 0, 1'b1);
        drive_cycle(4'b0001, bundle(branch_op(5, 6), '0, '0, '0), 4, 4, 0, 1'b0);
        idle_cycles(5);

        // store queue indices with fill and commit
        drive_cycle(4'b1111, stores, 4, 4, 0, 1'b0);
        drive_cycle(4'b1111, bundle(stores[0], stores[1], stores[2], alus[3]), 4, 4, 0, 1'b0);
        drive_cycle(4'b1111, bundle(alus[0], stores[1], stores[2], alus[3]), 4, 4, 0, 1'b0);
        drive_cycle(4'b1111, stores, 4, 4, 0, 1'b0);
        drive_cycle(4'b1111, stores, 4, 4, 4, 1'b0);
        drive_cycle(4'b1111, stores, 4, 4, 0, 1'b0);
        idle_cycles(4);

        // loads share the next store index
        drive_cycle(4'b1111, bundle(load_op(9, 1), store_op(1, 2), load_op(10, 1), store_op(3, 4)),
                    4, 4, 0, 1'b0);
        idle_cycles(4);

        random_cycles(RAND_CYCLES);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
